// ==== common/rs_pkg.sv ====
package rs_pkg;

    // size of the physical register file
    localparam int NUM_PREGS = 32;

    // physical register index
    // register 0 means no register, it is never clobbered and never forwarded
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;

    // operand and result value
    typedef logic [31:0] data_t;

    // functional-unit classes
    typedef enum logic [1:0]
    {
        FU_ALU = 2'd0,
        FU_MUL = 2'd1,
        FU_LSU = 2'd2,
        FU_CSR = 2'd3
    } fu_t;

    // one availability bit per class
    localparam int NUM_FU_CLASSES = 4;

endpackage

// ==== reservation_station/rs_entry_buffer.sv ====
`timescale 1ns/1ps

module rs_entry_buffer
    import rs_pkg::*;
#(
    parameter  int DEPTH = 8,
    localparam int TAG_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
)
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // dispatch
    input  logic                     dispatch_valid_i,
    input  preg_t                    dispatch_rd_i,
    input  preg_t                    dispatch_rs1_i,
    input  preg_t                    dispatch_rs2_i,
    input  logic                     dispatch_use_imm_i,
    input  fu_t                      dispatch_fu_i,
    output logic                     dispatch_ready_o,
    output logic [TAG_W-1:0]         dispatch_tag_o,
    // issue marking
    input  logic                     issue_fire_i,
    input  logic [TAG_W-1:0]         issue_idx_i,
    // write-back
    input  logic                     wb_valid_i,
    input  logic [TAG_W-1:0]         wb_tag_i,
    input  data_t                    wb_data_i,
    // per-entry state
    output logic  [DEPTH-1:0]        valid_o,
    output logic  [DEPTH-1:0]        issued_o,
    output logic  [DEPTH-1:0]        done_o,
    output preg_t [DEPTH-1:0]        rd_o,
    output preg_t [DEPTH-1:0]        rs1_o,
    output preg_t [DEPTH-1:0]        rs2_o,
    output logic  [DEPTH-1:0]        use_imm_o,
    output fu_t   [DEPTH-1:0]        fu_o,
    output data_t [DEPTH-1:0]        result_o,
    // commit
    output logic                     commit_valid_o,
    output logic [TAG_W-1:0]         commit_tag_o,
    output preg_t                    commit_rd_o,
    output data_t                    commit_result_o,
    input  logic                     commit_ack_i
);

    logic  [DEPTH-1:0] valid_q;
    logic  [DEPTH-1:0] issued_q;
    logic  [DEPTH-1:0] done_q;
    preg_t [DEPTH-1:0] rd_q;
    preg_t [DEPTH-1:0] rs1_q;
    preg_t [DEPTH-1:0] rs2_q;
    logic  [DEPTH-1:0] use_imm_q;
    fu_t   [DEPTH-1:0] fu_q;
    data_t [DEPTH-1:0] result_q;

    logic              alloc_fire;
    logic              commit_fire;
    logic              wb_hit;
    logic [TAG_W-1:0]  free_idx;

    // lowest free slot becomes the new tag
    always_comb
    begin
        free_idx = '0;
        for (int j = DEPTH - 1; j >= 0; j--)
        begin
            if (!valid_q[j])
            begin
                free_idx = TAG_W'(j);
            end
        end
    end

    // lowest completed entry is offered for commit
    always_comb
    begin
        commit_valid_o = 1'b0;
        commit_tag_o   = '0;
        for (int j = DEPTH - 1; j >= 0; j--)
        begin
            if (valid_q[j] && issued_q[j] && done_q[j])
            begin
                commit_valid_o = 1'b1;
                commit_tag_o   = TAG_W'(j);
            end
        end
    end

    assign dispatch_ready_o = !(&valid_q) && !flush_i;
    assign dispatch_tag_o   = free_idx;
    assign alloc_fire       = dispatch_valid_i && dispatch_ready_o;
    assign commit_fire      = commit_valid_o && commit_ack_i;
    // stray write-backs to free or unissued entries are dropped
    assign wb_hit           = wb_valid_i && valid_q[wb_tag_i] && issued_q[wb_tag_i];

    // entry flags, flush first, allocation last
    always_ff @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            valid_q  <= '0;
            issued_q <= '0;
            done_q   <= '0;
        end
        else
        begin
            for (int j = 0; j < DEPTH; j++)
            begin
                if (flush_i || (commit_fire && commit_tag_o == TAG_W'(j)))
                begin
                    valid_q[j]  <= 1'b0;
                    issued_q[j] <= 1'b0;
                    done_q[j]   <= 1'b0;
                end
                else if (wb_hit && wb_tag_i == TAG_W'(j))
                begin
                    done_q[j] <= 1'b1;
                end
                else if (issue_fire_i && issue_idx_i == TAG_W'(j))
                begin
                    issued_q[j] <= 1'b1;
                end
                else if (alloc_fire && free_idx == TAG_W'(j))
                begin
                    valid_q[j]  <= 1'b1;
                    issued_q[j] <= 1'b0;
                    done_q[j]   <= 1'b0;
                end
            end
        end
    end

    // instruction fields and captured result
    always_ff @(posedge clk_i)
    begin
        for (int j = 0; j < DEPTH; j++)
        begin
            if (alloc_fire && free_idx == TAG_W'(j))
            begin
                rd_q[j]      <= dispatch_rd_i;
                rs1_q[j]     <= dispatch_rs1_i;
                rs2_q[j]     <= dispatch_rs2_i;
                use_imm_q[j] <= dispatch_use_imm_i;
                fu_q[j]      <= dispatch_fu_i;
            end
            if (wb_hit && wb_tag_i == TAG_W'(j))
            begin
                result_q[j] <= wb_data_i;
            end
        end
    end

    assign valid_o         = valid_q;
    assign issued_o        = issued_q;
    assign done_o          = done_q;
    assign rd_o            = rd_q;
    assign rs1_o           = rs1_q;
    assign rs2_o           = rs2_q;
    assign use_imm_o       = use_imm_q;
    assign fu_o            = fu_q;
    assign result_o        = result_q;
    assign commit_rd_o     = rd_q[commit_tag_o];
    assign commit_result_o = result_q[commit_tag_o];

endmodule

// ==== reservation_station/rs_wakeup.sv ====
`timescale 1ns/1ps

module rs_wakeup
    import rs_pkg::*;
#(
    parameter int DEPTH = 8
)
(
    input  logic  [DEPTH-1:0] valid_i,
    input  logic  [DEPTH-1:0] issued_i,
    input  logic  [DEPTH-1:0] done_i,
    input  preg_t [DEPTH-1:0] rd_i,
    input  preg_t [DEPTH-1:0] rs1_i,
    input  preg_t [DEPTH-1:0] rs2_i,
    input  logic  [DEPTH-1:0] use_imm_i,
    input  fu_t   [DEPTH-1:0] fu_i,
    input  data_t [DEPTH-1:0] result_i,
    output logic  [DEPTH-1:0] ready_o,
    output data_t [DEPTH-1:0] rs1_data_o,
    output data_t [DEPTH-1:0] rs2_data_o,
    output logic  [DEPTH-1:0] rs1_fwd_o,
    output logic  [DEPTH-1:0] rs2_fwd_o
);

    logic [DEPTH-1:0] rs1_clob;
    logic [DEPTH-1:0] rs2_clob;

    // compare every source against the rd of every other live entry
    always_comb
    begin
        rs1_clob   = '0;
        rs2_clob   = '0;
        rs1_fwd_o  = '0;
        rs2_fwd_o  = '0;
        rs1_data_o = '0;
        rs2_data_o = '0;
        for (int j = 0; j < DEPTH; j++)
        begin
            for (int k = 0; k < DEPTH; k++)
            begin
                if (k != j && valid_i[k])
                begin
                    if (rs1_i[j] != '0 && rd_i[k] == rs1_i[j])
                    begin
                        rs1_clob[j] = 1'b1;
                        // csr results only reach consumers through the register file
                        if (done_i[k] && fu_i[k] != FU_CSR)
                        begin
                            rs1_fwd_o[j]  = 1'b1;
                            rs1_data_o[j] = result_i[k];
                        end
                    end
                    if (!use_imm_i[j] && rs2_i[j] != '0 && rd_i[k] == rs2_i[j])
                    begin
                        rs2_clob[j] = 1'b1;
                        if (done_i[k] && fu_i[k] != FU_CSR)
                        begin
                            rs2_fwd_o[j]  = 1'b1;
                            rs2_data_o[j] = result_i[k];
                        end
                    end
                end
            end
        end
    end

    // waiting entries whose operands are both available
    assign ready_o = valid_i & ~issued_i
                   & (~rs1_clob | rs1_fwd_o)
                   & (~rs2_clob | rs2_fwd_o | use_imm_i);

endmodule

// ==== reservation_station/rs_select.sv ====
`timescale 1ns/1ps

module rs_select
    import rs_pkg::*;
#(
    parameter  int DEPTH = 8,
    localparam int TAG_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
)
(
    input  logic [DEPTH-1:0]          ready_i,
    input  fu_t  [DEPTH-1:0]          fu_i,
    input  logic [NUM_FU_CLASSES-1:0] fu_ready_i,
    output logic                      issue_valid_o,
    output logic [TAG_W-1:0]          issue_idx_o
);

    logic [DEPTH-1:0] candidate;

    // ready entries whose unit class can take an instruction
    always_comb
    begin
        for (int j = 0; j < DEPTH; j++)
        begin
            candidate[j] = ready_i[j] && fu_ready_i[fu_i[j]];
        end
    end

    // scanning down leaves the lowest candidate
    always_comb
    begin
        issue_valid_o = 1'b0;
        issue_idx_o   = '0;
        for (int j = DEPTH - 1; j >= 0; j--)
        begin
            if (candidate[j])
            begin
                issue_valid_o = 1'b1;
                issue_idx_o   = TAG_W'(j);
            end
        end
    end

endmodule

// ==== reservation_station/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station
    import rs_pkg::*;
#(
    parameter  int DEPTH = 8,
    localparam int TAG_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
)
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    // dispatch
    input  logic                      dispatch_valid_i,
    input  preg_t                     dispatch_rd_i,
    input  preg_t                     dispatch_rs1_i,
    input  preg_t                     dispatch_rs2_i,
    input  logic                      dispatch_use_imm_i,
    input  fu_t                       dispatch_fu_i,
    output logic                      dispatch_ready_o,
    output logic [TAG_W-1:0]          dispatch_tag_o,
    // issue
    input  logic [NUM_FU_CLASSES-1:0] fu_ready_i,
    input  logic                      issue_ready_i,
    output logic                      issue_valid_o,
    output logic [TAG_W-1:0]          issue_tag_o,
    output fu_t                       issue_fu_o,
    output preg_t                     issue_rd_o,
    output data_t                     issue_rs1_data_o,
    output logic                      issue_rs1_fwd_o,
    output data_t                     issue_rs2_data_o,
    output logic                      issue_rs2_fwd_o,
    // write-back
    input  logic                      wb_valid_i,
    input  logic [TAG_W-1:0]          wb_tag_i,
    input  data_t                     wb_data_i,
    // commit
    output logic                      commit_valid_o,
    output logic [TAG_W-1:0]          commit_tag_o,
    output preg_t                     commit_rd_o,
    output data_t                     commit_result_o,
    input  logic                      commit_ack_i
);

    logic  [DEPTH-1:0] valid;
    logic  [DEPTH-1:0] issued;
    logic  [DEPTH-1:0] done;
    preg_t [DEPTH-1:0] rd;
    preg_t [DEPTH-1:0] rs1;
    preg_t [DEPTH-1:0] rs2;
    logic  [DEPTH-1:0] use_imm;
    fu_t   [DEPTH-1:0] fu;
    data_t [DEPTH-1:0] result;
    logic  [DEPTH-1:0] ready;
    data_t [DEPTH-1:0] rs1_data;
    data_t [DEPTH-1:0] rs2_data;
    logic  [DEPTH-1:0] rs1_fwd;
    logic  [DEPTH-1:0] rs2_fwd;
    logic [TAG_W-1:0]  issue_idx;
    logic              issue_fire;

    assign issue_fire = issue_valid_o && issue_ready_i;

    rs_entry_buffer #(
        .DEPTH (DEPTH)
    ) u_entry_buffer (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_rd_i      (dispatch_rd_i),
        .dispatch_rs1_i     (dispatch_rs1_i),
        .dispatch_rs2_i     (dispatch_rs2_i),
        .dispatch_use_imm_i (dispatch_use_imm_i),
        .dispatch_fu_i      (dispatch_fu_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .dispatch_tag_o     (dispatch_tag_o),
        .issue_fire_i       (issue_fire),
        .issue_idx_i        (issue_idx),
        .wb_valid_i         (wb_valid_i),
        .wb_tag_i           (wb_tag_i),
        .wb_data_i          (wb_data_i),
        .valid_o            (valid),
        .issued_o           (issued),
        .done_o             (done),
        .rd_o               (rd),
        .rs1_o              (rs1),
        .rs2_o              (rs2),
        .use_imm_o          (use_imm),
        .fu_o               (fu),
        .result_o           (result),
        .commit_valid_o     (commit_valid_o),
        .commit_tag_o       (commit_tag_o),
        .commit_rd_o        (commit_rd_o),
        .commit_result_o    (commit_result_o),
        .commit_ack_i       (commit_ack_i)
    );

    rs_wakeup #(
        .DEPTH (DEPTH)
    ) u_wakeup (
        .valid_i    (valid),
        .issued_i   (issued),
        .done_i     (done),
        .rd_i       (rd),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .use_imm_i  (use_imm),
        .fu_i       (fu),
        .result_i   (result),
        .ready_o    (ready),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rs1_fwd_o  (rs1_fwd),
        .rs2_fwd_o  (rs2_fwd)
    );

    rs_select #(
        .DEPTH (DEPTH)
    ) u_select (
        .ready_i       (ready),
        .fu_i          (fu),
        .fu_ready_i    (fu_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_idx_o   (issue_idx)
    );

    // payload of the selected entry
    assign issue_tag_o      = issue_idx;
    assign issue_fu_o       = fu[issue_idx];
    assign issue_rd_o       = rd[issue_idx];
    assign issue_rs1_data_o = rs1_data[issue_idx];
    assign issue_rs1_fwd_o  = rs1_fwd[issue_idx];
    assign issue_rs2_data_o = rs2_data[issue_idx];
    assign issue_rs2_fwd_o  = rs2_fwd[issue_idx];

endmodule

// ==== verif/rs_checker.sv ====
`timescale 1ns/1ps

module rs_checker
#(
    parameter int TAG_W = 3
)
(
    input logic             clk_i,
    input logic             rst_ni,
    input logic             flush_i,
    input logic             dispatch_valid_i,
    input logic             dispatch_ready_o,
    input logic             issue_valid_o,
    input logic             issue_ready_i,
    input logic [TAG_W-1:0] issue_tag_o,
    input logic [4:0]       issue_rd_o,
    input logic [31:0]      issue_rs1_data_o,
    input logic             commit_valid_o,
    input logic             commit_ack_i
);

    // held issue offer keeps its payload
    issue_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_o && !issue_ready_i && !flush_i |=> issue_valid_o
        && $stable(issue_tag_o) && $stable(issue_rd_o) && $stable(issue_rs1_data_o))
        else $error("issue payload changed under back-pressure");

    // a refused dispatch must not take a slot
    full_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dispatch_valid_i && !dispatch_ready_o && !flush_i
        && !(commit_valid_o && commit_ack_i) |=> !dispatch_ready_o)
        else $error("dispatch accepted while buffer was full");

    reset_idle: assert property (@(posedge clk_i)
        !rst_ni |=> !issue_valid_o && !commit_valid_o)
        else $error("valid outputs high after reset");

endmodule

bind reservation_station rs_checker #(.TAG_W(TAG_W)) u_checker (.*);

// ==== verif/tb_reservation_station.sv ====
`timescale 1ns/1ps

module tb_reservation_station
    import rs_pkg::*;
();

    localparam int DEPTH = 4;
    localparam int TAG_W = 2;

    typedef struct {
        logic             dv;
        preg_t            rd;
        preg_t            rs1;
        preg_t            rs2;
        logic             imm;
        fu_t              fu;
        logic [3:0]       fur;
        logic             ir;
        logic             wbv;
        logic [TAG_W-1:0] wbt;
        logic             ack;
        logic             fl;
        logic             exp_iv;
        logic [TAG_W-1:0] exp_tag;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic flush_i;
    logic dispatch_valid_i;
    preg_t dispatch_rd_i;
    preg_t dispatch_rs1_i;
    preg_t dispatch_rs2_i;
    logic dispatch_use_imm_i;
    fu_t dispatch_fu_i;
    logic [NUM_FU_CLASSES-1:0] fu_ready_i;
    logic issue_ready_i;
    logic wb_valid_i;
    logic [TAG_W-1:0] wb_tag_i;
    data_t wb_data_i;
    logic commit_ack_i;
    logic dispatch_ready_o;
    logic [TAG_W-1:0] dispatch_tag_o;
    logic issue_valid_o;
    logic [TAG_W-1:0] issue_tag_o;
    fu_t issue_fu_o;
    preg_t issue_rd_o;
    data_t issue_rs1_data_o;
    logic issue_rs1_fwd_o;
    data_t issue_rs2_data_o;
    logic issue_rs2_fwd_o;
    logic commit_valid_o;
    logic [TAG_W-1:0] commit_tag_o;
    preg_t commit_rd_o;
    data_t commit_result_o;

    row_t  table_q[$];
    logic [31:0] lfsr_state = 32'd32735;
    int    cycle_count = 0;
    int    cycle_limit = 1000;

    // reference model of the entry buffer
    logic  m_valid[DEPTH];
    logic  m_issued[DEPTH];
    logic  m_done[DEPTH];
    preg_t m_rd[DEPTH];
    preg_t m_rs1[DEPTH];
    preg_t m_rs2[DEPTH];
    logic  m_imm[DEPTH];
    fu_t   m_fu[DEPTH];
    data_t m_res[DEPTH];

    reservation_station #(.DEPTH(DEPTH)) u_dut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: stimulus table did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one lfsr step per data bit
    task automatic random_word(output data_t w);
        for (int i = 0; i < 32; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic dv, input int rd, input int rs1, input int rs2,
                           input logic imm, input fu_t fu, input logic [3:0] fur,
                           input logic ir, input logic wbv, input int wbt, input logic ack,
                           input logic fl, input logic exp_iv, input int exp_tag);
        row_t r;
        r.dv = dv;
        r.rd = preg_t'(rd);
        r.rs1 = preg_t'(rs1);
        r.rs2 = preg_t'(rs2);
        r.imm = imm;
        r.fu = fu;
        r.fur = fur;
        r.ir = ir;
        r.wbv = wbv;
        r.wbt = TAG_W'(wbt);
        r.ack = ack;
        r.fl = fl;
        r.exp_iv = exp_iv;
        r.exp_tag = TAG_W'(exp_tag);
        table_q.push_back(r);
    endtask

    // check one cycle against the model, then advance the model past the edge
    task automatic apply_and_check(input row_t r, input data_t wdata);
        logic f1[DEPTH];
        logic f2[DEPTH];
        data_t d1[DEPTH];
        data_t d2[DEPTH];
        logic rdy[DEPTH];
        logic c1;
        logic c2;
        logic dready;
        int free_i;
        int iss_i;
        int com_i;
        logic alloc;
        logic wb_hit;
        free_i = -1;
        iss_i = -1;
        com_i = -1;
        for (int j = 0; j < DEPTH; j++)
        begin
            f1[j] = 1'b0;
            f2[j] = 1'b0;
            d1[j] = '0;
            d2[j] = '0;
            c1 = 1'b0;
            c2 = 1'b0;
            for (int k = 0; k < DEPTH; k++)
            begin
                if (k != j && m_valid[k] && m_rs1[j] != 0 && m_rd[k] == m_rs1[j])
                begin
                    c1 = 1'b1;
                    if (m_done[k] && m_fu[k] != FU_CSR)
                    begin
                        f1[j] = 1'b1;
                        d1[j] = m_res[k];
                    end
                end
                if (k != j && m_valid[k] && !m_imm[j] && m_rs2[j] != 0
                    && m_rd[k] == m_rs2[j])
                begin
                    c2 = 1'b1;
                    if (m_done[k] && m_fu[k] != FU_CSR)
                    begin
                        f2[j] = 1'b1;
                        d2[j] = m_res[k];
                    end
                end
            end
            rdy[j] = m_valid[j] && !m_issued[j] && (!c1 || f1[j]) && (!c2 || f2[j] || m_imm[j]);
            if (free_i < 0 && !m_valid[j])
                free_i = j;
            if (iss_i < 0 && rdy[j] && r.fur[m_fu[j]])
                iss_i = j;
            if (com_i < 0 && m_valid[j] && m_issued[j] && m_done[j])
                com_i = j;
        end
        dready = (free_i >= 0) && !r.fl;
        check("dispatch_ready_o", dispatch_ready_o, dready);
        if (dready)
            check("dispatch_tag_o", dispatch_tag_o, free_i);
        check("issue_valid_o", issue_valid_o, iss_i >= 0);
        check("issue_valid_o (table)", issue_valid_o, r.exp_iv);
        if (iss_i >= 0)
        begin
            check("issue_tag_o (table)", issue_tag_o, r.exp_tag);
            check("issue_tag_o", issue_tag_o, iss_i);
            check("issue_fu_o", issue_fu_o, m_fu[iss_i]);
            check("issue_rd_o", issue_rd_o, m_rd[iss_i]);
            check("issue_rs1_fwd_o", issue_rs1_fwd_o, f1[iss_i]);
            check("issue_rs1_data_o", issue_rs1_data_o, d1[iss_i]);
            check("issue_rs2_fwd_o", issue_rs2_fwd_o, f2[iss_i]);
            check("issue_rs2_data_o", issue_rs2_data_o, d2[iss_i]);
        end
        check("commit_valid_o", commit_valid_o, com_i >= 0);
        if (com_i >= 0)
        begin
            check("commit_tag_o", commit_tag_o, com_i);
            check("commit_rd_o", commit_rd_o, m_rd[com_i]);
            check("commit_result_o", commit_result_o, m_res[com_i]);
        end
        alloc = r.dv && dready;
        wb_hit = r.wbv && m_valid[r.wbt] && m_issued[r.wbt];
        for (int j = 0; j < DEPTH; j++)
        begin
            if (r.fl || (r.ack && com_i == j))
            begin
                m_valid[j] = 1'b0;
                m_issued[j] = 1'b0;
                m_done[j] = 1'b0;
            end
            else if (wb_hit && r.wbt == j)
            begin
                m_done[j] = 1'b1;
                m_res[j] = wdata;
            end
            else if (r.ir && iss_i == j)
                m_issued[j] = 1'b1;
            else if (alloc && free_i == j)
            begin
                m_valid[j] = 1'b1;
                m_issued[j] = 1'b0;
                m_done[j] = 1'b0;
                m_rd[j] = r.rd;
                m_rs1[j] = r.rs1;
                m_rs2[j] = r.rs2;
                m_imm[j] = r.imm;
                m_fu[j] = r.fu;
            end
        end
    endtask

    initial
    begin
        data_t wdata;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_rd_i = '0;
        dispatch_rs1_i = '0;
        dispatch_rs2_i = '0;
        dispatch_use_imm_i = 1'b0;
        dispatch_fu_i = FU_ALU;
        fu_ready_i = '1;
        issue_ready_i = 1'b0;
        wb_valid_i = 1'b0;
        wb_tag_i = '0;
        wb_data_i = '0;
        commit_ack_i = 1'b0;
        for (int j = 0; j < DEPTH; j++)
        begin
            m_valid[j] = 1'b0;
            m_issued[j] = 1'b0;
            m_done[j] = 1'b0;
            m_rd[j] = '0;
            m_rs1[j] = '0;
            m_rs2[j] = '0;
            m_imm[j] = 1'b0;
            m_fu[j] = FU_ALU;
            m_res[j] = '0;
        end

        // dv rd rs1 rs2 imm fu fur ir wbv wbt ack fl | expected issue valid, tag
        // four independent instructions, a refused fifth, then issue in tag order
        add_row(1, 1, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 2, 0, 0, 1, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 1, 0);
        add_row(1, 3, 0, 0, 0, FU_MUL, 4'hF, 0, 0, 0, 0, 0, 1, 0);
        add_row(1, 4, 0, 0, 0, FU_LSU, 4'hF, 0, 0, 0, 0, 0, 1, 0);
        add_row(1, 8, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 1);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 2);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 3);
        // write-back, commit and reuse of tag 0 by a consumer of r3
        // its rs2 names the busy r4 but is an immediate
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 1, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 1, 1, 1, 0, 0, 0);
        add_row(1, 5, 3, 4, 1, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 1, 2, 1, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 1, 3, 1, 0, 0, 0);
        // mul class blocked, alu entry passes it
        add_row(1, 6, 0, 0, 0, FU_MUL, 4'hF, 0, 0, 0, 1, 0, 0, 0);
        add_row(1, 7, 0, 0, 0, FU_ALU, 4'hD, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hD, 0, 0, 0, 0, 0, 1, 2);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hD, 1, 0, 0, 0, 0, 1, 2);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 0, 0, 1, 1);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 0, 0);
        // csr producer is never forwarded
        add_row(1, 9, 0, 0, 0, FU_CSR, 4'hF, 0, 1, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 1, 0, 0, 1, 0, 1, 3);
        add_row(1, 10, 9, 0, 0, FU_ALU, 4'hF, 0, 1, 3, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 1, 0, 0, 0);
        add_row(1, 13, 0, 0, 0, FU_ALU, 4'hF, 1, 1, 1, 0, 0, 1, 0);
        // flush with an issue and a commit on offer
        add_row(1, 12, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 1, 1, 3);
        add_row(1, 11, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, FU_ALU, 4'hF, 0, 0, 0, 0, 0, 1, 0);
        cycle_limit = table_q.size() + 20;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (table_q[i])
        begin
            @(negedge clk_i);
            wdata = '0;
            if (table_q[i].wbv)
                random_word(wdata);
            flush_i = table_q[i].fl;
            dispatch_valid_i = table_q[i].dv;
            dispatch_rd_i = table_q[i].rd;
            dispatch_rs1_i = table_q[i].rs1;
            dispatch_rs2_i = table_q[i].rs2;
            dispatch_use_imm_i = table_q[i].imm;
            dispatch_fu_i = table_q[i].fu;
            fu_ready_i = table_q[i].fur;
            issue_ready_i = table_q[i].ir;
            wb_valid_i = table_q[i].wbv;
            wb_tag_i = table_q[i].wbt;
            wb_data_i = wdata;
            commit_ack_i = table_q[i].ack;
            #1;
            apply_and_check(table_q[i], wdata);
        end

        @(negedge clk_i);
        dispatch_valid_i = 1'b0;
        issue_ready_i = 1'b0;
        wb_valid_i = 1'b0;
        commit_ack_i = 1'b0;
        flush_i = 1'b0;
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== project.f ====
common/rs_pkg.sv
reservation_station/rs_entry_buffer.sv
reservation_station/rs_wakeup.sv
reservation_station/rs_select.sv
reservation_station/reservation_station.sv
verif/rs_checker.sv
verif/tb_reservation_station.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_reservation_station
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
